// File: Bender.yml
package:
  name: wiscExec

sources:
  - include_dirs:
      - .
    files:
      - wiscPkg.sv
      - control.sv
      - immGen.sv
      - aluExec.sv
      - wiscExec.sv
  - target: test
    include_dirs:
      - .
    files:
      - wiscExec_properties.sv
      - wiscExecChecker.sv
      - tb_wiscExec.sv

// File: aluExec.sv
//##########################################################################
// ALU, address and next-PC logic with one register stage on every output.
// Control flags drop low on cycles without instrValid; data outputs hold.
// For loads writeData carries the address and wbSrc selects load data.
//##########################################################################

`include "wisc_defines.svh"

module aluExec (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instrValid,
    input  wiscPkg::aluOp_t       aluOp,
    input  wiscPkg::bSrc_t        bSrc,
    input  wiscPkg::brKind_t      brKind,
    input  wiscPkg::wbSrc_t       ctlWbSrc,   // Decoded, not yet registered
    input  logic                  ctlRegWrite,
    input  logic [`REG_IDX_W-1:0] ctlWriteReg,
    input  logic                  ctlMemRead,
    input  logic                  ctlMemWrite,
    input  logic                  ctlHalt,
    input  logic                  ctlOpErr,
    input  logic [`WISC_W-1:0]    imm,
    input  logic [`WISC_W-1:0]    rsData,
    input  logic [`WISC_W-1:0]    rtData,
    input  logic [`WISC_W-1:0]    pc,
    output logic                  outValid,
    output logic                  regWrite,
    output logic [`REG_IDX_W-1:0] writeReg,
    output logic [`WISC_W-1:0]    writeData,
    output wiscPkg::wbSrc_t       wbSrc,
    output logic                  memRead,
    output logic                  memWrite,
    output logic [`WISC_W-1:0]    memAddr,
    output logic [`WISC_W-1:0]    storeData,
    output logic [`WISC_W-1:0]    nextPc,
    output logic                  halt,
    output logic                  opErr
);
    import wiscPkg::*;

    localparam int W = `WISC_W;

    logic [W-1:0]   opB;
    logic [W:0]     sum;                      // Carry in top bit for SCO
    logic [3:0]     shAmt;
    logic [2*W-1:0] rotL;
    logic [2*W-1:0] rotR;
    logic [W-1:0]   btrRev;
    logic [W-1:0]   aluResult;
    logic [W-1:0]   rsPlusImm;
    logic [W-1:0]   pcInc;
    logic           taken;
    logic [W-1:0]   nextPcComb;
    logic [W-1:0]   writeDataComb;

    assign opB       = (bSrc == B_IMM) ? imm : rtData;
    assign sum       = {1'b0, rsData} + {1'b0, opB};
    assign shAmt     = opB[3:0];
    assign rotL      = {rsData, rsData} << shAmt;
    assign rotR      = {rsData, rsData} >> shAmt;
    assign rsPlusImm = rsData + imm;          // Memory address and JR target
    assign pcInc     = pc + W'(2);

    always_comb begin
        for (int i = 0; i < W; i++) begin
            btrRev[i] = rsData[W-1-i];
        end
    end

    always_comb begin
        case (aluOp)
            ADD:     aluResult = sum[W-1:0];
            SUB:     aluResult = opB - rsData;  // B minus A
            XOR:     aluResult = rsData ^ opB;
            ANDN:    aluResult = rsData & ~opB;
            ROL:     aluResult = rotL[2*W-1:W];
            SLL:     aluResult = rsData << shAmt;
            ROR:     aluResult = rotR[W-1:0];
            SRL:     aluResult = rsData >> shAmt;
            SEQ:     aluResult = W'(rsData == opB);
            SLT:     aluResult = W'($signed(rsData) < $signed(opB));
            SLE:     aluResult = W'($signed(rsData) <= $signed(opB));
            SCO:     aluResult = W'(sum[W]);
            BTR:     aluResult = btrRev;
            SLBI:    aluResult = (rsData << 8) | opB;
            default: aluResult = opB;           // PASSB, LBI
        endcase
    end

    always_comb begin
        case (brKind)
            BEQZ:    taken = (rsData == '0);
            BNEZ:    taken = (rsData != '0);
            BLTZ:    taken = rsData[W-1];
            BGEZ:    taken = ~rsData[W-1];
            JUMPREL: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign nextPcComb    = (brKind == JUMPREG) ? rsPlusImm :
                           taken               ? pcInc + imm : pcInc;
    assign writeDataComb = (ctlWbSrc == WB_PC2) ? pcInc : aluResult;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid  <= 1'b0;
            regWrite  <= 1'b0;
            memRead   <= 1'b0;
            memWrite  <= 1'b0;
            halt      <= 1'b0;
            opErr     <= 1'b0;
            writeReg  <= '0;
            writeData <= '0;
            wbSrc     <= WB_ALU;
            memAddr   <= '0;
            storeData <= '0;
            nextPc    <= '0;
        end else begin
            outValid <= instrValid;
            regWrite <= instrValid & ctlRegWrite;
            memRead  <= instrValid & ctlMemRead;
            memWrite <= instrValid & ctlMemWrite;
            halt     <= instrValid & ctlHalt;
            opErr    <= instrValid & ctlOpErr;
            if (instrValid) begin
                writeReg  <= ctlWriteReg;
                writeData <= writeDataComb;
                wbSrc     <= ctlWbSrc;
                memAddr   <= rsPlusImm;
                storeData <= rtData;
                nextPc    <= nextPcComb;
            end
        end
    end

endmodule

// File: control.sv
//##########################################################################
// Opcode decoder, purely combinational. Covers the full 32-entry opcode
// table; siic and RTI behave as NOP. The immediate is chosen in immGen,
// so nothing here depends on its width or extension.
//##########################################################################

`include "wisc_defines.svh"

module control (
    input  wiscPkg::instrWord_t   instr,
    output wiscPkg::aluOp_t       aluOp,
    output wiscPkg::bSrc_t        bSrc,
    output wiscPkg::brKind_t      brKind,
    output wiscPkg::wbSrc_t       wbSrc,
    output logic                  regWrite,
    output logic [`REG_IDX_W-1:0] writeReg,
    output logic                  memRead,
    output logic                  memWrite,
    output logic                  halt,
    output logic                  opErr
);
    import wiscPkg::*;

    logic [4:0] opcode;
    logic [1:0] funct;

    assign opcode = instr.rFmt.opcode;
    assign funct  = instr.rFmt.funct;

    always_comb begin
        aluOp    = PASSB;
        bSrc     = B_REG;
        brKind   = SEQUENTIAL;
        wbSrc    = WB_ALU;
        regWrite = 1'b0;
        writeReg = instr.rFmt.rd; // R format destination
        memRead  = 1'b0;
        memWrite = 1'b0;
        halt     = 1'b0;
        opErr    = 1'b0;

        casez (opcode)
            5'b00000: halt = 1'b1;
            5'b00001, 5'b0001?: begin
                // NOP, siic, RTI
            end

            5'b00100: brKind = JUMPREL; // J
            5'b00101: brKind = JUMPREG; // JR
            5'b00110: begin             // JAL
                brKind   = JUMPREL;
                regWrite = 1'b1;
                writeReg = `LINK_REG;
                wbSrc    = WB_PC2;
            end
            5'b00111: begin             // JALR
                brKind   = JUMPREG;
                regWrite = 1'b1;
                writeReg = `LINK_REG;
                wbSrc    = WB_PC2;
            end

            5'b010??, 5'b101??: begin   // ADDI..ANDNI, ROLI..SRLI
                aluOp    = aluOp_t'({1'b0, opcode[4], opcode[1:0]});
                bSrc     = B_IMM;
                regWrite = 1'b1;
                writeReg = instr.i1Fmt.rd;
            end

            5'b011??: begin             // Zero-test branches
                case (opcode[1:0])
                    2'b00:   brKind = BEQZ;
                    2'b01:   brKind = BNEZ;
                    2'b10:   brKind = BLTZ;
                    default: brKind = BGEZ;
                endcase
            end

            5'b10000: begin             // ST
                aluOp    = ADD;
                bSrc     = B_IMM;
                memWrite = 1'b1;
            end
            5'b10001: begin             // LD
                aluOp    = ADD;
                bSrc     = B_IMM;
                memRead  = 1'b1;
                regWrite = 1'b1;
                writeReg = instr.i1Fmt.rd;
                wbSrc    = WB_MEM;      // Outside picks load data
            end
            5'b10010: begin             // SLBI
                aluOp    = SLBI;
                bSrc     = B_IMM;
                regWrite = 1'b1;
                writeReg = instr.i2Fmt.rs;
            end
            5'b10011: begin             // STU, address goes back to Rs
                aluOp    = ADD;
                bSrc     = B_IMM;
                memWrite = 1'b1;
                regWrite = 1'b1;
                writeReg = instr.i2Fmt.rs;
            end

            5'b11000: begin             // LBI
                aluOp    = PASSB;
                bSrc     = B_IMM;
                regWrite = 1'b1;
                writeReg = instr.i2Fmt.rs;
            end
            5'b11001: begin             // BTR
                aluOp    = BTR;
                regWrite = 1'b1;
            end

            // 11011 is ADD/SUB/XOR/ANDN, 11010 is ROL/SLL/ROR/SRL
            5'b1101?: begin
                aluOp    = aluOp_t'({1'b0, ~opcode[0], funct});
                regWrite = 1'b1;
            end

            5'b111??: begin             // SEQ, SLT, SLE, SCO
                aluOp    = aluOp_t'({2'b10, opcode[1:0]});
                regWrite = 1'b1;
            end

            default: opErr = 1'b1;      // No writes for bad opcode
        endcase
    end

endmodule

// File: immGen.sv
//##########################################################################
// Immediate extraction. Field and extension come from the opcode only;
// opcodes without an immediate give zero.
//##########################################################################

`include "wisc_defines.svh"

module immGen (
    input  wiscPkg::instrWord_t instr,
    output logic [`WISC_W-1:0]  imm
);
    localparam int W = `WISC_W;

    logic [4:0] opcode;

    assign opcode = instr.jFmt.opcode;

    always_comb begin
        casez (opcode)
            // XORI, ANDNI and the immediate shifts
            5'b0101?, 5'b101??:
                imm = {{(W-5){1'b0}}, instr.i1Fmt.imm5};
            // ADDI, SUBI, ST, LD, STU
            5'b0100?, 5'b1000?, 5'b10011:
                imm = {{(W-5){instr.i1Fmt.imm5[4]}}, instr.i1Fmt.imm5};
            // Branches, LBI, JR, JALR
            5'b011??, 5'b11000, 5'b00101, 5'b00111:
                imm = {{(W-8){instr.i2Fmt.imm8[7]}}, instr.i2Fmt.imm8};
            5'b10010:                   // SLBI
                imm = {{(W-8){1'b0}}, instr.i2Fmt.imm8};
            5'b00100, 5'b00110:         // J, JAL
                imm = {{(W-11){instr.jFmt.disp11[10]}}, instr.jFmt.disp11};
            default:
                imm = '0;
        endcase
    end

endmodule

// File: tb_wiscExec.sv
//##########################################################################
// Testbench for wiscExec. Seeded random instructions over all 32 opcodes,
// with random operands and an even PC; instrValid high about 80% of cycles.
// Results are compared in wiscExecChecker, bound assertions add to the verdict.
//##########################################################################

`include "wisc_defines.svh"

module tb_wiscExec;
    localparam int numInstr    = 3000;
    localparam int resetCycles = 16;
    localparam int clkPeriod   = 4;
    localparam int timeoutTime = (resetCycles + numInstr * 2) * clkPeriod;

    logic                  clk;
    logic                  rst;
    logic                  instrValid;
    logic [`WISC_W-1:0]    instr;
    logic [`WISC_W-1:0]    rsData;
    logic [`WISC_W-1:0]    rtData;
    logic [`WISC_W-1:0]    pc;
    logic                  outValid;
    logic                  regWrite;
    logic [`REG_IDX_W-1:0] writeReg;
    logic [`WISC_W-1:0]    writeData;
    wiscPkg::wbSrc_t       wbSrc;
    logic                  memRead;
    logic                  memWrite;
    logic [`WISC_W-1:0]    memAddr;
    logic [`WISC_W-1:0]    storeData;
    logic [`WISC_W-1:0]    nextPc;
    logic                  halt;
    logic                  opErr;
    int                    seed;
    int                    sent;
    int                    checkCount;
    int                    errCount;
    int                    resultCount;
    int                    assertFails;

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    wiscExec dut_i (.*);

    wiscExecChecker checker_i (.*);

    bind wiscExec wiscExec_properties props_i (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .outValid   (outValid),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .halt       (halt),
        .opErr      (opErr)
    );

    // Random fields also on idle cycles, to exercise the gating
    task automatic driveRandom();
        instrValid = ({$random(seed)} % 10) < 8;
        instr      = `WISC_W'($random(seed));    // Opcode, fields and funct
        rsData     = ({$random(seed)} % 8 == 0) ? '0 : `WISC_W'($random(seed));
        rtData     = `WISC_W'($random(seed));
        pc         = `WISC_W'($random(seed));
        pc[0]      = 1'b0;
    endtask

    initial begin
        seed       = 48;
        sent       = 0;
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        rsData     = '0;
        rtData     = '0;
        pc         = '0;
        repeat (resetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
        while (sent < numInstr) begin
            driveRandom();
            if (instrValid) sent++;
            @(posedge clk);
            #1;
        end
        instrValid = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        assertFails = dut_i.props_i.failCount;
        if (resultCount != numInstr) begin
            $display("Result count wrong: sent %0d instructions, checker saw %0d results",
                     numInstr, resultCount);
        end
        $display("Checks %0d, mismatches %0d, assertion failures %0d",
                 checkCount, errCount, assertFails);
        if (errCount == 0 && assertFails == 0 && resultCount == numInstr) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(timeoutTime);
        $display("Timeout: the run did not finish within %0d time units", timeoutTime);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: wiscExec.f
+incdir+.
wiscPkg.sv
control.sv
immGen.sv
aluExec.sv
wiscExec.sv
wiscExec_properties.sv
wiscExecChecker.sv
tb_wiscExec.sv

// File: wiscExec.sv
//##########################################################################
// Decode and execute slice top. One-cycle latency, no back-pressure.
// Register file, memory and fetch are outside; rsData and rtData must be
// the registers named by instr bits 10:8 and 7:5.
//##########################################################################

`include "wisc_defines.svh"

module wiscExec (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instrValid,
    input  logic [`WISC_W-1:0]    instr,
    input  logic [`WISC_W-1:0]    rsData,
    input  logic [`WISC_W-1:0]    rtData,
    input  logic [`WISC_W-1:0]    pc,
    output logic                  outValid,
    output logic                  regWrite,
    output logic [`REG_IDX_W-1:0] writeReg,
    output logic [`WISC_W-1:0]    writeData,
    output wiscPkg::wbSrc_t       wbSrc,
    output logic                  memRead,
    output logic                  memWrite,
    output logic [`WISC_W-1:0]    memAddr,
    output logic [`WISC_W-1:0]    storeData,
    output logic [`WISC_W-1:0]    nextPc,
    output logic                  halt,
    output logic                  opErr
);
    import wiscPkg::*;

    aluOp_t                aluOp;
    bSrc_t                 bSrc;
    brKind_t               brKind;
    wbSrc_t                ctlWbSrc;
    logic                  ctlRegWrite;
    logic [`REG_IDX_W-1:0] ctlWriteReg;
    logic                  ctlMemRead;
    logic                  ctlMemWrite;
    logic                  ctlHalt;
    logic                  ctlOpErr;
    logic [`WISC_W-1:0]    imm;

    control control_i (
        .instr    (instr),
        .aluOp    (aluOp),
        .bSrc     (bSrc),
        .brKind   (brKind),
        .wbSrc    (ctlWbSrc),
        .regWrite (ctlRegWrite),
        .writeReg (ctlWriteReg),
        .memRead  (ctlMemRead),
        .memWrite (ctlMemWrite),
        .halt     (ctlHalt),
        .opErr    (ctlOpErr)
    );

    immGen immGen_i (
        .instr (instr),
        .imm   (imm)
    );

    aluExec aluExec_i (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .aluOp       (aluOp),
        .bSrc        (bSrc),
        .brKind      (brKind),
        .ctlWbSrc    (ctlWbSrc),
        .ctlRegWrite (ctlRegWrite),
        .ctlWriteReg (ctlWriteReg),
        .ctlMemRead  (ctlMemRead),
        .ctlMemWrite (ctlMemWrite),
        .ctlHalt     (ctlHalt),
        .ctlOpErr    (ctlOpErr),
        .imm         (imm),
        .rsData      (rsData),
        .rtData      (rtData),
        .pc          (pc),
        .outValid    (outValid),
        .regWrite    (regWrite),
        .writeReg    (writeReg),
        .writeData   (writeData),
        .wbSrc       (wbSrc),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .memAddr     (memAddr),
        .storeData   (storeData),
        .nextPc      (nextPc),
        .halt        (halt),
        .opErr       (opErr)
    );

endmodule

// File: wiscExecChecker.sv
//##########################################################################
// Reference model and scoreboard for wiscExec. Inputs are captured at each
// rising edge, outputs compared at the following falling edge. The model
// follows the WISC opcode table directly and assumes 16-bit words.
//##########################################################################

`include "wisc_defines.svh"

module wiscExecChecker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instrValid,
    input  logic [`WISC_W-1:0]    instr,
    input  logic [`WISC_W-1:0]    rsData,
    input  logic [`WISC_W-1:0]    rtData,
    input  logic [`WISC_W-1:0]    pc,
    input  logic                  outValid,
    input  logic                  regWrite,
    input  logic [`REG_IDX_W-1:0] writeReg,
    input  logic [`WISC_W-1:0]    writeData,
    input  logic [1:0]            wbSrc,
    input  logic                  memRead,
    input  logic                  memWrite,
    input  logic [`WISC_W-1:0]    memAddr,
    input  logic [`WISC_W-1:0]    storeData,
    input  logic [`WISC_W-1:0]    nextPc,
    input  logic                  halt,
    input  logic                  opErr,
    output int                    checkCount,
    output int                    errCount,
    output int                    resultCount
);
    localparam logic [1:0] wbFromAlu = 2'd0;
    localparam logic [1:0] wbFromMem = 2'd1;
    localparam logic [1:0] wbFromPc  = 2'd2;   // Link value pc+2

    logic        primed;
    logic        expValid;
    logic        expRegWrite;
    logic [2:0]  expWriteReg;
    logic [15:0] expWriteData;
    logic [1:0]  expWbSrc;
    logic        expMemRead;
    logic        expMemWrite;
    logic [15:0] expMemAddr;
    logic [15:0] expStoreData;
    logic [15:0] expNextPc;
    logic        expHalt;
    logic        expOpErr;
    logic [4:0]  expOpcode;

    function automatic logic [15:0] rotl(input logic [15:0] x, input logic [3:0] n);
        return (x << n) | (x >> (5'd16 - n));
    endfunction

    function automatic logic [15:0] rotr(input logic [15:0] x, input logic [3:0] n);
        return (x >> n) | (x << (5'd16 - n));
    endfunction

    function automatic logic [15:0] reverse(input logic [15:0] x);
        logic [15:0] r;
        for (int i = 0; i < 16; i++) begin
            r[15-i] = x[i];
        end
        return r;
    endfunction

    task automatic clearExpect();
        expValid     = 1'b0;
        expRegWrite  = 1'b0;
        expWriteReg  = '0;
        expWriteData = '0;
        expWbSrc     = wbFromAlu;
        expMemRead   = 1'b0;
        expMemWrite  = 1'b0;
        expMemAddr   = '0;
        expStoreData = '0;
        expNextPc    = '0;
        expHalt      = 1'b0;
        expOpErr     = 1'b0;
    endtask

    task automatic setWrite(input logic [2:0] idx, input logic [15:0] data,
                            input logic [1:0] src);
        expRegWrite  = 1'b1;
        expWriteReg  = idx;
        expWriteData = data;
        expWbSrc     = src;
    endtask

    task automatic setMem(input logic rd, input logic wr, input logic [15:0] addr);
        expMemRead  = rd;
        expMemWrite = wr;
        expMemAddr  = addr;
    endtask

    // a is Rs, b is Rt
    task automatic predict(input logic [15:0] ins, input logic [15:0] a,
                           input logic [15:0] b, input logic [15:0] pcIn);
        logic [4:0]  op;
        logic [2:0]  rdR;
        logic [2:0]  rdI1;
        logic [2:0]  rsIdx;
        logic [15:0] imm5s;
        logic [15:0] imm5z;
        logic [15:0] imm8s;
        logic [15:0] disp11s;
        logic [15:0] pc2;
        logic [3:0]  shI;
        logic [3:0]  shR;
        logic [16:0] carrySum;
        op       = ins[15:11];
        rsIdx    = ins[10:8];
        rdI1     = ins[7:5];
        rdR      = ins[4:2];
        imm5s    = {{11{ins[4]}}, ins[4:0]};
        imm5z    = {11'b0, ins[4:0]};
        imm8s    = {{8{ins[7]}}, ins[7:0]};
        disp11s  = {{5{ins[10]}}, ins[10:0]};
        pc2      = pcIn + 16'd2;
        shI      = ins[3:0];
        shR      = b[3:0];
        carrySum = {1'b0, a} + {1'b0, b};
        expValid     = 1'b1;
        expOpcode    = op;
        expNextPc    = pc2;
        expStoreData = b;
        case (op)
            5'b00000: expHalt = 1'b1;
            5'b00001, 5'b00010, 5'b00011: begin
                // NOP, siic, RTI leave everything but the PC alone
            end
            5'b00100: expNextPc = pc2 + disp11s;              // J
            5'b00101: expNextPc = a + imm8s;                  // JR
            5'b00110: begin                                   // JAL
                expNextPc = pc2 + disp11s;
                setWrite(3'd7, pc2, wbFromPc);
            end
            5'b00111: begin                                   // JALR
                expNextPc = a + imm8s;
                setWrite(3'd7, pc2, wbFromPc);
            end
            5'b01000: setWrite(rdI1, a + imm5s, wbFromAlu);   // ADDI
            5'b01001: setWrite(rdI1, imm5s - a, wbFromAlu);   // SUBI
            5'b01010: setWrite(rdI1, a ^ imm5z, wbFromAlu);   // XORI
            5'b01011: setWrite(rdI1, a & ~imm5z, wbFromAlu);  // ANDNI
            5'b01100: if (a == 16'h0) expNextPc = pc2 + imm8s;
            5'b01101: if (a != 16'h0) expNextPc = pc2 + imm8s;
            5'b01110: if (a[15]) expNextPc = pc2 + imm8s;
            5'b01111: if (!a[15]) expNextPc = pc2 + imm8s;
            5'b10000: setMem(1'b0, 1'b1, a + imm5s);          // ST
            5'b10001: begin                                   // LD
                setMem(1'b1, 1'b0, a + imm5s);
                setWrite(rdI1, a + imm5s, wbFromMem);
            end
            5'b10010: setWrite(rsIdx, {a[7:0], ins[7:0]}, wbFromAlu);
            5'b10011: begin                                   // STU
                setMem(1'b0, 1'b1, a + imm5s);
                setWrite(rsIdx, a + imm5s, wbFromAlu);
            end
            5'b10100: setWrite(rdI1, rotl(a, shI), wbFromAlu);
            5'b10101: setWrite(rdI1, a << shI, wbFromAlu);
            5'b10110: setWrite(rdI1, rotr(a, shI), wbFromAlu);
            5'b10111: setWrite(rdI1, a >> shI, wbFromAlu);
            5'b11000: setWrite(rsIdx, imm8s, wbFromAlu);      // LBI
            5'b11001: setWrite(rdR, reverse(a), wbFromAlu);   // BTR
            5'b11010: begin
                case (ins[1:0])
                    2'b00:   setWrite(rdR, rotl(a, shR), wbFromAlu);
                    2'b01:   setWrite(rdR, a << shR, wbFromAlu);
                    2'b10:   setWrite(rdR, rotr(a, shR), wbFromAlu);
                    default: setWrite(rdR, a >> shR, wbFromAlu);
                endcase
            end
            5'b11011: begin
                case (ins[1:0])
                    2'b00:   setWrite(rdR, a + b, wbFromAlu);
                    2'b01:   setWrite(rdR, b - a, wbFromAlu);
                    2'b10:   setWrite(rdR, a ^ b, wbFromAlu);
                    default: setWrite(rdR, a & ~b, wbFromAlu);
                endcase
            end
            5'b11100: setWrite(rdR, {15'b0, a == b}, wbFromAlu);
            5'b11101: setWrite(rdR, {15'b0, $signed(a) < $signed(b)}, wbFromAlu);
            5'b11110: setWrite(rdR, {15'b0, $signed(a) <= $signed(b)}, wbFromAlu);
            5'b11111: setWrite(rdR, {15'b0, carrySum[16]}, wbFromAlu);
            default:  expOpErr = 1'b1;
        endcase
    endtask

    task automatic checkValue(input string name, input logic [15:0] expv,
                              input logic [15:0] act);
        checkCount++;
        if (act !== expv) begin
            errCount++;
            $display("MISMATCH %s expected %h actual %h (opcode %b, time %0t)",
                     name, expv, act, expOpcode, $time);
        end
    endtask

    initial begin
        primed      = 1'b0;
        checkCount  = 0;
        errCount    = 0;
        resultCount = 0;
        expOpcode   = '0;
        clearExpect();
    end

    always @(posedge clk) begin
        primed = 1'b1;
        clearExpect();
        if (!rst && instrValid) begin
            predict(instr, rsData, rtData, pc);
        end
    end

    // Registered outputs are settled by the falling edge
    always @(negedge clk) begin
        if (primed) begin
            if (outValid === 1'b1) begin
                resultCount++;          // Results the DUT actually gave
            end
            checkValue("outValid", expValid, outValid);
            checkValue("regWrite", expRegWrite, regWrite);
            checkValue("memRead", expMemRead, memRead);
            checkValue("memWrite", expMemWrite, memWrite);
            checkValue("halt", expHalt, halt);
            checkValue("opErr", expOpErr, opErr);
            if (expValid) begin
                checkValue("nextPc", expNextPc, nextPc);
                if (expRegWrite) begin
                    checkValue("writeReg", expWriteReg, writeReg);
                    checkValue("writeData", expWriteData, writeData);
                    checkValue("wbSrc", expWbSrc, wbSrc);
                end
                if (expMemRead || expMemWrite) begin
                    checkValue("memAddr", expMemAddr, memAddr);
                    checkValue("storeData", expStoreData, storeData);
                end
            end
        end
    end

endmodule

// File: wiscExec_properties.sv
//##########################################################################
// Output sanity properties, bound into wiscExec. Assumes the synchronous,
// active-high reset of the DUT and a one-cycle instrValid strobe.
//##########################################################################

module wiscExec_properties (
    input logic clk,
    input logic rst,
    input logic instrValid,
    input logic outValid,
    input logic memRead,
    input logic memWrite,
    input logic halt,
    input logic opErr
);
    int failCount;

    initial failCount = 0;

    validLowAfterReset: assert property (@(posedge clk) rst |=> !outValid)
        else begin
            $error("outValid was high in the cycle after reset");
            failCount++;
        end

    noMemWithoutValid: assert property (@(posedge clk) disable iff (rst)
        !outValid |-> !(memRead || memWrite))
        else begin
            $error("Memory request raised while outValid was low");
            failCount++;
        end

    haltOpErrExclusive: assert property (@(posedge clk) disable iff (rst) !(halt && opErr))
        else begin
            $error("halt and opErr were high together");
            failCount++;
        end

    // One-cycle latency from strobe to result
    validFollowsStrobe: assert property (@(posedge clk)
        !rst |=> (outValid == $past(instrValid)))
        else begin
            $error("outValid did not follow instrValid by one cycle");
            failCount++;
        end

endmodule

// File: wiscPkg.sv
//##########################################################################
// Instruction formats and decoded control types. Enum encodings are relied
// on by the decoder, which builds aluOp from opcode and funct bits.
//##########################################################################

`include "wisc_defines.svh"

package wiscPkg;

    typedef struct packed {
        logic [4:0]            opcode;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rt;
        logic [`REG_IDX_W-1:0] rd;
        logic [1:0]            funct;
    } rFmt_t;

    typedef struct packed {
        logic [4:0]            opcode;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rd;
        logic [4:0]            imm5;
    } i1Fmt_t;

    typedef struct packed {
        logic [4:0]            opcode;
        logic [`REG_IDX_W-1:0] rs;
        logic [7:0]            imm8;
    } i2Fmt_t;

    typedef struct packed {
        logic [4:0]  opcode;
        logic [10:0] disp11;
    } jFmt_t;

    // One word, four views; opcode sits in the same bits in all of them
    typedef union packed {
        rFmt_t  rFmt;
        i1Fmt_t i1Fmt;
        i2Fmt_t i2Fmt;
        jFmt_t  jFmt;
    } instrWord_t;

    typedef enum logic [3:0] {
        ADD  = 4'd0,  SUB  = 4'd1,  XOR  = 4'd2,  ANDN  = 4'd3,
        ROL  = 4'd4,  SLL  = 4'd5,  ROR  = 4'd6,  SRL   = 4'd7,
        SEQ  = 4'd8,  SLT  = 4'd9,  SLE  = 4'd10, SCO   = 4'd11,
        BTR  = 4'd12, PASSB = 4'd13, SLBI = 4'd14
    } aluOp_t;

    typedef enum logic {B_REG, B_IMM} bSrc_t;

    typedef enum logic [2:0] {
        SEQUENTIAL, BEQZ, BNEZ, BLTZ, BGEZ, JUMPREL, JUMPREG
    } brKind_t;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC2} wbSrc_t;

endpackage

// File: wisc_defines.svh
//##########################################################################
// Widths shared by the decode and execute slice. Data and instruction
// words are the same width; the register file has eight entries.
//##########################################################################

`ifndef WISC_DEFINES_SVH
`define WISC_DEFINES_SVH

// Data, address and instruction word width
`define WISC_W 16

// Register index width, eight registers
`define REG_IDX_W 3

// JAL and JALR write the return address here
`define LINK_REG (`REG_IDX_W'(7))

`endif
